// File: verilog/procPkg.sv
//******************************
// shared encodings and pipeline bundles for the five-stage core
// instruction fields follow the 32-bit word-addressed format
// an all-zero word decodes as add r0, r0, r0 and serves as the bubble
//******************************
package procPkg;

    // machine word and register number widths
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth     = 17;
    localparam int targetWidth  = 27;

    // instruction field positions
    localparam int opcodeHi = 31;
    localparam int opcodeLo = 27;
    localparam int rdHi     = 26;
    localparam int rdLo     = 22;
    localparam int rsHi     = 21;
    localparam int rsLo     = 17;
    localparam int rtHi     = 16;
    localparam int rtLo     = 12;
    localparam int shamtHi  = 11;
    localparam int shamtLo  = 7;
    localparam int aluOpHi  = 6;
    localparam int aluOpLo  = 2;

    // opcodes
    localparam logic [4:0] opAlu  = 5'b00000;
    localparam logic [4:0] opJ    = 5'b00001;
    localparam logic [4:0] opBne  = 5'b00010;
    localparam logic [4:0] opJal  = 5'b00011;
    localparam logic [4:0] opJr   = 5'b00100;
    localparam logic [4:0] opAddi = 5'b00101;
    localparam logic [4:0] opBlt  = 5'b00110;
    localparam logic [4:0] opSw   = 5'b00111;
    localparam logic [4:0] opLw   = 5'b01000;

    // alu function codes
    localparam logic [4:0] aluAdd = 5'b00000;
    localparam logic [4:0] aluSub = 5'b00001;
    localparam logic [4:0] aluAnd = 5'b00010;
    localparam logic [4:0] aluOr  = 5'b00011;
    localparam logic [4:0] aluSll = 5'b00100;
    localparam logic [4:0] aluSra = 5'b00101;

    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;
    localparam logic [regAddrWidth-1:0] zeroReg = 5'd0;

    // decoded control, travels with the instruction
    typedef struct packed {
        logic                    regWrite;
        logic                    memWrite;
        logic                    memRead;
        logic                    useImm;
        logic                    isBne;
        logic                    isBlt;
        logic                    isJal;
        logic [4:0]              aluOp;
        logic [regAddrWidth-1:0] shamt;
        logic [regAddrWidth-1:0] writeReg;
    } ctrlT;

    typedef struct packed {
        logic [dataWidth-1:0] pcPlusOne;
        logic [dataWidth-1:0] instr;
    } fdT;

    typedef struct packed {
        logic [dataWidth-1:0]    pcPlusOne;
        ctrlT                    ctrl;
        logic [regAddrWidth-1:0] readRegA;
        logic [regAddrWidth-1:0] readRegB;
        logic [dataWidth-1:0]    valueA;
        logic [dataWidth-1:0]    valueB;
        logic [dataWidth-1:0]    imm;
    } dxT;

    typedef struct packed {
        ctrlT                 ctrl;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] storeValue;
    } xmT;

    typedef struct packed {
        ctrlT                 ctrl;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] loadData;
    } mwT;

    typedef struct packed {
        logic                    writeEnable;
        logic [regAddrWidth-1:0] writeReg;
        logic [dataWidth-1:0]    value;
    } wbT;

endpackage

// File: verilog/procAlu.sv
//******************************
// combinational alu, no overflow detection
// shifts use shamt only, operandB is ignored for them
//******************************
`timescale 1ns/10ps

module procAlu import procPkg::*; (
    input  logic [dataWidth-1:0]    operandA,
    input  logic [dataWidth-1:0]    operandB,
    input  logic [4:0]              aluOp,
    input  logic [regAddrWidth-1:0] shamt,
    output logic [dataWidth-1:0]    result,
    output logic                    isNotEqual,
    output logic                    isLessThan
);

    // compare flags are independent of aluOp
    assign isNotEqual = operandA != operandB;
    assign isLessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = operandA + operandB;
            end
            aluSub: begin
                result = operandA - operandB;
            end
            aluAnd: begin
                result = operandA & operandB;
            end
            aluOr: begin
                result = operandA | operandB;
            end
            aluSll: begin
                result = operandA << shamt;
            end
            aluSra: begin
                result = $unsigned($signed(operandA) >>> shamt);
            end
            // unused codes give zero
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: verilog/fetchUnit.sv
//******************************
// program counter and fetch/decode register
// instruction memory read is assumed combinational
// j and jal redirect here with no lost slot
//******************************
`timescale 1ns/10ps

module fetchUnit import procPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [dataWidth-1:0] qImem,
    input  logic                 stall,
    input  logic                 jrTaken,
    input  logic                 branchTaken,
    input  logic [dataWidth-1:0] jrTarget,
    input  logic [dataWidth-1:0] branchTarget,
    output logic [dataWidth-1:0] addressImem,
    output fdT                   fd
);

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlusOne;
    logic [dataWidth-1:0] pcNext;
    logic [dataWidth-1:0] jumpTarget;
    logic [4:0]           fetchOp;
    logic                 isJump;

    assign addressImem = pc;
    assign pcPlusOne   = pc + dataWidth'(1);

    // j / jal spotted straight off the memory output
    assign fetchOp    = qImem[opcodeHi:opcodeLo];
    assign isJump     = (fetchOp == opJ) || (fetchOp == opJal);
    assign jumpTarget = {{(dataWidth - targetWidth){1'b0}}, qImem[targetWidth-1:0]};

    // older redirects win over younger ones
    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (jrTaken) begin
            pcNext = jrTarget;
        end else if (stall) begin
            pcNext = pc;
        end else if (isJump) begin
            pcNext = jumpTarget;
        end else begin
            pcNext = pcPlusOne;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // flush beats hold
    always_ff @(posedge clock) begin
        if (reset) begin
            fd <= '0;
        end else if (branchTaken || jrTaken) begin
            fd <= '0;
        end else if (!stall) begin
            fd.pcPlusOne <= pcPlusOne;
            fd.instr     <= qImem;
        end
    end

endmodule

// File: verilog/decodeUnit.sv
//******************************
// decode, hazard detection and decode/execute register
// register file read must return same-cycle write data
// jr stalls until its source is in memory stage or later
//******************************
`timescale 1ns/10ps

module decodeUnit import procPkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  fdT                      fd,
    input  logic [dataWidth-1:0]    dataReadRegA,
    input  logic [dataWidth-1:0]    dataReadRegB,
    input  xmT                      xm,
    input  wbT                      wb,
    input  logic                    branchTaken,
    output logic [regAddrWidth-1:0] ctrlReadRegA,
    output logic [regAddrWidth-1:0] ctrlReadRegB,
    output logic                    stall,
    output logic                    jrTaken,
    output logic [dataWidth-1:0]    jrTarget,
    output dxT                      dx
);

    logic [4:0]              opcode;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic                    isAlu, isAddi, isSw, isLw, isBne, isBlt, isJal, isJr;
    logic                    portBIsRd;
    logic                    portBRead;
    logic                    loadUse;
    logic                    jrWait;
    logic                    jrFromXm;
    logic                    jrFromWb;
    logic [dataWidth-1:0]    immExt;
    ctrlT                    ctrl;

    assign opcode = fd.instr[opcodeHi:opcodeLo];
    assign rd     = fd.instr[rdHi:rdLo];
    assign rs     = fd.instr[rsHi:rsLo];
    assign rt     = fd.instr[rtHi:rtLo];

    assign isAlu  = opcode == opAlu;
    assign isAddi = opcode == opAddi;
    assign isSw   = opcode == opSw;
    assign isLw   = opcode == opLw;
    assign isBne  = opcode == opBne;
    assign isBlt  = opcode == opBlt;
    assign isJal  = opcode == opJal;
    assign isJr   = opcode == opJr;

    // port B carries rd for store data, branch compare and jr
    assign portBIsRd    = isSw | isBne | isBlt | isJr;
    assign ctrlReadRegA = rs;
    assign ctrlReadRegB = portBIsRd ? rd : rt;
    // sw data is fixed up later by the store bypass
    assign portBRead    = isAlu | isBne | isBlt | isJr;

    assign immExt = {{(dataWidth - immWidth){fd.instr[immWidth-1]}}, fd.instr[immWidth-1:0]};

    always_comb begin
        ctrl          = '0;
        ctrl.regWrite = isAlu | isAddi | isLw | isJal;
        ctrl.memWrite = isSw;
        ctrl.memRead  = isLw;
        ctrl.useImm   = isAddi | isLw | isSw;
        ctrl.isBne    = isBne;
        ctrl.isBlt    = isBlt;
        ctrl.isJal    = isJal;
        ctrl.aluOp    = isAlu ? fd.instr[aluOpHi:aluOpLo] : aluAdd;
        ctrl.shamt    = fd.instr[shamtHi:shamtLo];
        // for sw this names the data register, used by the store bypass
        ctrl.writeReg = isJal ? linkReg : rd;
    end

    // load in execute feeding this instruction
    assign loadUse = dx.ctrl.memRead &&
                     ((dx.ctrl.writeReg == rs) ||
                      (portBRead && (dx.ctrl.writeReg == ctrlReadRegB)));

    // jr source still in execute, or a load still in memory
    assign jrWait = isJr && (rd != zeroReg) &&
                    ((dx.ctrl.regWrite && (dx.ctrl.writeReg == rd)) ||
                     (xm.ctrl.memRead && (xm.ctrl.writeReg == rd)));

    assign stall = loadUse | jrWait;

    // jr target bypass, nearest producer first
    assign jrFromXm = xm.ctrl.regWrite && !xm.ctrl.memRead &&
                      (xm.ctrl.writeReg == rd) && (rd != zeroReg);
    assign jrFromWb = wb.writeEnable && (wb.writeReg == rd);
    assign jrTarget = jrFromXm ? xm.result : (jrFromWb ? wb.value : dataReadRegB);
    assign jrTaken  = isJr && !stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            dx <= '0;
        end else if (stall || branchTaken) begin
            dx <= '0;
        end else begin
            dx.pcPlusOne <= fd.pcPlusOne;
            dx.ctrl      <= ctrl;
            dx.readRegA  <= rs;
            dx.readRegB  <= ctrlReadRegB;
            dx.valueA    <= dataReadRegA;
            dx.valueB    <= dataReadRegB;
            dx.imm       <= immExt;
        end
    end

endmodule

// File: verilog/executeUnit.sv
//******************************
// operand bypass, alu and branch resolution
// a taken bne/blt flushes the two younger instructions
// loads are never bypassed from the memory stage
//******************************
`timescale 1ns/10ps

module executeUnit import procPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  dxT                   dx,
    input  wbT                   wb,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget,
    output xmT                   xm
);

    logic [dataWidth-1:0] valueA;
    logic [dataWidth-1:0] valueB;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    logic                 notEqual;
    logic                 lessThan;

    // memory stage first, then writeback, else the decoded value
    function automatic logic [dataWidth-1:0] bypass(
        input logic [regAddrWidth-1:0] readReg,
        input logic [dataWidth-1:0]    regValue,
        input xmT                      xmStage,
        input wbT                      wbStage
    );
        logic fromXm;
        logic fromWb;
        fromXm = xmStage.ctrl.regWrite && !xmStage.ctrl.memRead &&
                 (xmStage.ctrl.writeReg == readReg) && (readReg != zeroReg);
        fromWb = wbStage.writeEnable && (wbStage.writeReg == readReg);
        if (fromXm) begin
            return xmStage.result;
        end else if (fromWb) begin
            return wbStage.value;
        end
        return regValue;
    endfunction

    assign valueA = bypass(dx.readRegA, dx.valueA, xm, wb);
    assign valueB = bypass(dx.readRegB, dx.valueB, xm, wb);
    assign aluB   = dx.ctrl.useImm ? dx.imm : valueB;

    // branches compare rs (A side) against rd (B side)
    procAlu u_dataAlu (
        .operandA   (valueA),
        .operandB   (aluB),
        .aluOp      (dx.ctrl.aluOp),
        .shamt      (dx.ctrl.shamt),
        .result     (aluResult),
        .isNotEqual (notEqual),
        .isLessThan (lessThan)
    );

    // pc-plus-one plus offset
    procAlu u_targetAlu (
        .operandA   (dx.pcPlusOne),
        .operandB   (dx.imm),
        .aluOp      (aluAdd),
        .shamt      (zeroReg),
        .result     (branchTarget),
        .isNotEqual (),
        .isLessThan ()
    );

    // blt: rd < rs, i.e. rs greater than rd
    assign branchTaken = (dx.ctrl.isBne && notEqual) ||
                         (dx.ctrl.isBlt && notEqual && !lessThan);

    always_ff @(posedge clock) begin
        if (reset) begin
            xm <= '0;
        end else begin
            xm.ctrl       <= dx.ctrl;
            // jal links to the slot after itself
            xm.result     <= dx.ctrl.isJal ? dx.pcPlusOne : aluResult;
            xm.storeValue <= valueB;
        end
    end

endmodule

// File: verilog/memWriteback.sv
//******************************
// data memory access and memory/writeback register
// data memory read is combinational, write on rising edge
// r0 writes are dropped here
//******************************
`timescale 1ns/10ps

module memWriteback import procPkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  xmT                   xm,
    input  logic [dataWidth-1:0] qDmem,
    output logic [dataWidth-1:0] addressDmem,
    output logic [dataWidth-1:0] data,
    output logic                 wren,
    output wbT                   wb
);

    mwT   mw;
    logic storeBypass;

    assign addressDmem = xm.result;
    assign wren        = xm.ctrl.memWrite;

    // sw carries its data register in writeReg
    // catches a load sitting right ahead of the store
    assign storeBypass = xm.ctrl.memWrite && wb.writeEnable &&
                         (wb.writeReg == xm.ctrl.writeReg);
    assign data        = storeBypass ? wb.value : xm.storeValue;

    always_ff @(posedge clock) begin
        if (reset) begin
            mw <= '0;
        end else begin
            mw.ctrl     <= xm.ctrl;
            mw.result   <= xm.result;
            mw.loadData <= qDmem;
        end
    end

    // writeback select
    assign wb.writeEnable = mw.ctrl.regWrite && (mw.ctrl.writeReg != zeroReg);
    assign wb.writeReg    = mw.ctrl.writeReg;
    assign wb.value       = mw.ctrl.memRead ? mw.loadData : mw.result;

endmodule

// File: verilog/processor.sv
//******************************
// five-stage pipelined core
// memories and register file live outside
// no multiply/divide, no overflow exception
//******************************
`timescale 1ns/10ps

module processor import procPkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    output logic [dataWidth-1:0]    addressImem,
    input  logic [dataWidth-1:0]    qImem,
    output logic [dataWidth-1:0]    addressDmem,
    output logic [dataWidth-1:0]    data,
    output logic                    wren,
    input  logic [dataWidth-1:0]    qDmem,
    output logic                    ctrlWriteEnable,
    output logic [regAddrWidth-1:0] ctrlWriteReg,
    output logic [regAddrWidth-1:0] ctrlReadRegA,
    output logic [regAddrWidth-1:0] ctrlReadRegB,
    output logic [dataWidth-1:0]    dataWriteReg,
    input  logic [dataWidth-1:0]    dataReadRegA,
    input  logic [dataWidth-1:0]    dataReadRegB
);

    fdT                   fd;
    dxT                   dx;
    xmT                   xm;
    wbT                   wb;
    logic                 stall;
    logic                 jrTaken;
    logic                 branchTaken;
    logic [dataWidth-1:0] jrTarget;
    logic [dataWidth-1:0] branchTarget;

    fetchUnit u_fetch (
        .clock, .reset, .qImem, .stall, .jrTaken, .branchTaken,
        .jrTarget, .branchTarget, .addressImem, .fd
    );

    decodeUnit u_decode (
        .clock, .reset, .fd, .dataReadRegA, .dataReadRegB, .xm, .wb,
        .branchTaken, .ctrlReadRegA, .ctrlReadRegB, .stall, .jrTaken,
        .jrTarget, .dx
    );

    executeUnit u_execute (
        .clock, .reset, .dx, .wb, .branchTaken, .branchTarget, .xm
    );

    memWriteback u_memWb (
        .clock, .reset, .xm, .qDmem, .addressDmem, .data, .wren, .wb
    );

    // register file write port
    assign ctrlWriteEnable = wb.writeEnable;
    assign ctrlWriteReg    = wb.writeReg;
    assign dataWriteReg    = wb.value;

endmodule

// File: sim/tbMemories.sv
//******************************
// memory and register file models for the core
// 256-word instruction and data memories, index from address bits 7:0
// reads are combinational, writes land on the rising edge
// register file read returns same-cycle write data
//******************************
`timescale 1ns/10ps

module tbMemories import procPkg::*; (
    input  logic                    clock,
    input  logic [dataWidth-1:0]    addressImem,
    output logic [dataWidth-1:0]    qImem,
    input  logic [dataWidth-1:0]    addressDmem,
    input  logic [dataWidth-1:0]    data,
    input  logic                    wren,
    output logic [dataWidth-1:0]    qDmem,
    input  logic                    ctrlWriteEnable,
    input  logic [regAddrWidth-1:0] ctrlWriteReg,
    input  logic [regAddrWidth-1:0] ctrlReadRegA,
    input  logic [regAddrWidth-1:0] ctrlReadRegB,
    input  logic [dataWidth-1:0]    dataWriteReg,
    output logic [dataWidth-1:0]    dataReadRegA,
    output logic [dataWidth-1:0]    dataReadRegB
);

    // filled by the testbench before each program
    logic [dataWidth-1:0] imem [256];
    logic [dataWidth-1:0] dmem [256];
    logic [dataWidth-1:0] regs [32];

    assign qImem = imem[addressImem[7:0]];
    assign qDmem = dmem[addressDmem[7:0]];

    // r0 reads zero, write-through otherwise
    assign dataReadRegA = (ctrlReadRegA == zeroReg) ? '0 :
                          (ctrlWriteEnable && ctrlWriteReg == ctrlReadRegA) ? dataWriteReg :
                          regs[ctrlReadRegA];
    assign dataReadRegB = (ctrlReadRegB == zeroReg) ? '0 :
                          (ctrlWriteEnable && ctrlWriteReg == ctrlReadRegB) ? dataWriteReg :
                          regs[ctrlReadRegB];

    always @(posedge clock) begin
        if (ctrlWriteEnable && ctrlWriteReg != zeroReg) begin
            regs[ctrlWriteReg] <= dataWriteReg;
        end
        if (wren) begin
            dmem[addressDmem[7:0]] <= data;
        end
    end

endmodule

// File: sim/processorTb.sv
//******************************
// testbench for the pipelined core
// four programs, each ending in a jump to itself
// a sequential model predicts register and memory writes
// unused instruction words hold a jump to their own address
//******************************
`timescale 1ns/10ps

module processorTb import procPkg::*; ();

    typedef struct packed {
        logic [4:0]  num;
        logic [31:0] value;
    } regWriteT;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] value;
    } memWriteT;

    logic        clock;
    logic        reset;
    logic [31:0] addressImem;
    logic [31:0] qImem;
    logic [31:0] addressDmem;
    logic [31:0] data;
    logic        wren;
    logic [31:0] qDmem;
    logic        ctrlWriteEnable;
    logic [4:0]  ctrlWriteReg;
    logic [4:0]  ctrlReadRegA;
    logic [4:0]  ctrlReadRegB;
    logic [31:0] dataWriteReg;
    logic [31:0] dataReadRegA;
    logic [31:0] dataReadRegB;

    // expected writes, oldest first
    regWriteT    regQ[$];
    memWriteT    memQ[$];
    logic [31:0] prog[$];
    logic [31:0] image [256];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [256];
    int          seed;
    int          regErrors;
    int          memErrors;
    int          otherErrors;
    int          settle;

    processor u_dut (.*);
    tbMemories u_mem (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] rOp(logic [4:0] fn, int rd, int rs, int rt, int sh);
        return {opAlu, 5'(rd), 5'(rs), 5'(rt), 5'(sh), fn, 2'b00};
    endfunction

    // addi, lw, sw, bne, blt, jr
    function automatic logic [31:0] iOp(logic [4:0] op, int rd, int rs, int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic logic [31:0] jOp(logic [4:0] op, int target);
        return {op, 27'(target)};
    endfunction

    task automatic buildProgram(int which);
        prog.delete();
        case (which)
            // dependent alu chain
            0: begin
                prog.push_back(iOp(opAddi, 1, 0, 5));
                prog.push_back(iOp(opAddi, 2, 1, -3));
                prog.push_back(rOp(aluAdd, 3, 1, 2, 0));
                prog.push_back(rOp(aluSub, 4, 3, 1, 0));
                prog.push_back(rOp(aluAnd, 5, 4, 3, 0));
                prog.push_back(rOp(aluOr, 6, 5, 2, 0));
                prog.push_back(rOp(aluSll, 7, 6, 0, 4));
                prog.push_back(rOp(aluSub, 9, 0, 7, 0));
                prog.push_back(rOp(aluSra, 10, 9, 0, 3));
                prog.push_back(iOp(opAddi, 11, 10, 100));
                prog.push_back(rOp(aluAdd, 12, 20, 21, 0));
                prog.push_back(rOp(aluSra, 13, 22, 0, 7));
                prog.push_back(rOp(aluSub, 14, 12, 13, 0));
                prog.push_back(jOp(opJ, 13));
            end
            // loads, stores and load-use
            1: begin
                prog.push_back(iOp(opAddi, 1, 0, 10));
                prog.push_back(iOp(opSw, 1, 1, 3));
                prog.push_back(iOp(opLw, 2, 1, 3));
                prog.push_back(rOp(aluAdd, 3, 2, 1, 0));
                prog.push_back(iOp(opLw, 4, 0, 5));
                prog.push_back(rOp(aluAdd, 5, 1, 4, 0));
                prog.push_back(iOp(opLw, 6, 0, 7));
                prog.push_back(iOp(opSw, 6, 0, 20));
                prog.push_back(iOp(opAddi, 7, 6, 1));
                prog.push_back(iOp(opSw, 7, 0, 21));
                prog.push_back(iOp(opLw, 8, 0, 21));
                prog.push_back(iOp(opSw, 8, 8, 30));
                prog.push_back(iOp(opLw, 9, 0, 20));
                prog.push_back(jOp(opJ, 13));
            end
            // taken and not-taken branches, short loop
            2: begin
                prog.push_back(iOp(opAddi, 1, 0, 3));
                prog.push_back(iOp(opAddi, 2, 0, 7));
                prog.push_back(iOp(opBne, 1, 2, 2));
                prog.push_back(iOp(opAddi, 3, 0, 111));
                prog.push_back(iOp(opAddi, 4, 0, 222));
                prog.push_back(iOp(opBlt, 1, 2, 1));
                prog.push_back(iOp(opAddi, 5, 0, 333));
                prog.push_back(iOp(opBlt, 2, 1, 1));
                prog.push_back(iOp(opAddi, 6, 0, 444));
                prog.push_back(iOp(opBne, 1, 1, 1));
                prog.push_back(iOp(opAddi, 8, 0, 0));
                prog.push_back(iOp(opAddi, 8, 8, 1));
                prog.push_back(iOp(opBlt, 8, 2, -2));
                prog.push_back(iOp(opBlt, 20, 21, 1));
                prog.push_back(iOp(opAddi, 9, 8, 5));
                prog.push_back(jOp(opJ, 15));
            end
            // jal, jr through the link and through a fresh value
            default: begin
                prog.push_back(iOp(opAddi, 1, 0, 6));
                prog.push_back(jOp(opJal, 5));
                prog.push_back(iOp(opAddi, 2, 0, 9));
                prog.push_back(iOp(opAddi, 4, 0, 10));
                prog.push_back(iOp(opJr, 4, 0, 0));
                prog.push_back(iOp(opAddi, 3, 31, 0));
                prog.push_back(iOp(opJr, 31, 0, 0));
                prog.push_back(iOp(opAddi, 9, 0, 97));
                prog.push_back(iOp(opAddi, 9, 0, 98));
                prog.push_back(iOp(opAddi, 9, 0, 99));
                prog.push_back(iOp(opAddi, 6, 0, 8));
                prog.push_back(iOp(opAddi, 7, 6, 1));
                prog.push_back(jOp(opJ, 12));
            end
        endcase
    endtask

    // same random contents go to the models and the memories
    task automatic loadProgram();
        logic [31:0] value;
        int          i;
        for (i = 0; i < 256; i++) begin
            image[i] = (i < prog.size()) ? prog[i] : {opJ, 27'(i)};
            u_mem.imem[i] = image[i];
            value = $random(seed);
            modelMem[i] = value;
            u_mem.dmem[i] = value;
        end
        for (i = 0; i < 32; i++) begin
            value = (i == 0) ? 32'd0 : $random(seed);
            modelRegs[i] = value;
            u_mem.regs[i] = value;
        end
    endtask

    task automatic modelWrite(logic [4:0] num, logic [31:0] value);
        if (num != 5'd0) begin
            modelRegs[num] = value;
            regQ.push_back({num, value});
        end
    endtask

    // one instruction per step, no pipeline
    task automatic runModel();
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] target;
        logic [4:0]  rd;
        logic        halted;
        int          steps;
        pc = 32'd0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 500) begin
            instr = image[pc[7:0]];
            rd = instr[26:22];
            a = modelRegs[instr[21:17]];
            // rd doubles as a source for sw, branches and jr
            b = modelRegs[rd];
            imm = {{15{instr[16]}}, instr[16:0]};
            target = {5'd0, instr[26:0]};
            next = pc + 32'd1;
            case (instr[31:27])
                opAlu: begin
                    case (instr[6:2])
                        aluAdd: modelWrite(rd, a + modelRegs[instr[16:12]]);
                        aluSub: modelWrite(rd, a - modelRegs[instr[16:12]]);
                        aluAnd: modelWrite(rd, a & modelRegs[instr[16:12]]);
                        aluOr:  modelWrite(rd, a | modelRegs[instr[16:12]]);
                        aluSll: modelWrite(rd, a << instr[11:7]);
                        default: modelWrite(rd, $signed(a) >>> instr[11:7]);
                    endcase
                end
                opAddi: modelWrite(rd, a + imm);
                opLw: modelWrite(rd, modelMem[(a + imm) % 256]);
                opSw: begin
                    modelMem[(a + imm) % 256] = b;
                    memQ.push_back({a + imm, b});
                end
                opBne: next = (b != a) ? pc + 32'd1 + imm : next;
                opBlt: next = ($signed(b) < $signed(a)) ? pc + 32'd1 + imm : next;
                opJal: begin
                    modelWrite(linkReg, pc + 32'd1);
                    next = target;
                end
                opJr: next = b;
                default: begin
                    halted = (target == pc);
                    next = target;
                end
            endcase
            pc = next;
            steps++;
        end
        if (!halted) begin
            $display("reference model never reached the closing self jump");
            otherErrors++;
        end
    endtask

    task automatic checkRegWrite();
        regWriteT expected;
        if (regQ.size() == 0) begin
            $display("unexpected register write to r%0d at %0t", ctrlWriteReg, $time);
            regErrors++;
        end else begin
            expected = regQ.pop_front();
            assert (ctrlWriteReg == expected.num) else begin
                $display("Fail at %0t: ctrlWriteReg is %0d, expected %0d",
                         $time, ctrlWriteReg, expected.num);
                regErrors++;
            end
            assert (dataWriteReg == expected.value) else begin
                $display("Fail at %0t: dataWriteReg is %h, expected %h",
                         $time, dataWriteReg, expected.value);
                regErrors++;
            end
        end
    endtask

    task automatic checkMemWrite();
        memWriteT expected;
        if (memQ.size() == 0) begin
            $display("unexpected memory write to %h at %0t", addressDmem, $time);
            memErrors++;
        end else begin
            expected = memQ.pop_front();
            assert (addressDmem == expected.address) else begin
                $display("Fail at %0t: addressDmem is %h, expected %h",
                         $time, addressDmem, expected.address);
                memErrors++;
            end
            assert (data == expected.value) else begin
                $display("Fail at %0t: data is %h, expected %h", $time, data, expected.value);
                memErrors++;
            end
        end
    endtask

    // mid-cycle sampling, strobes are settled here
    always @(negedge clock) begin
        if (reset || settle < 2) begin
            assert (ctrlWriteEnable !== 1'b1 && wren !== 1'b1) else begin
                $display("write strobe active during or just after reset at %0t", $time);
                otherErrors++;
            end
        end
        // first cycle out of reset fetches from address zero
        if (!reset && settle == 0) begin
            assert (addressImem === 32'd0) else begin
                $display("Fail at %0t: addressImem is %h, expected %h",
                         $time, addressImem, 32'd0);
                otherErrors++;
            end
        end
        if (ctrlWriteEnable === 1'b1) begin
            checkRegWrite();
        end
        if (wren === 1'b1) begin
            checkMemWrite();
        end
        settle = reset ? 0 : settle + 1;
    end

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while ((regQ.size() != 0 || memQ.size() != 0) && cycles < 2000) begin
            @(posedge clock);
            cycles++;
        end
        if (regQ.size() != 0 || memQ.size() != 0) begin
            $display("timeout with %0d register and %0d memory writes still missing",
                     regQ.size(), memQ.size());
            otherErrors++;
            regQ.delete();
            memQ.delete();
        end
    endtask

    initial begin
        int p;
        reset = 1'b1;
        seed = 99849;
        regErrors = 0;
        memErrors = 0;
        otherErrors = 0;
        settle = 0;
        for (p = 0; p < 4; p++) begin
            buildProgram(p);
            loadProgram();
            runModel();
            repeat (5) @(posedge clock);
            #1 reset = 1'b0;
            waitDrain();
            // idle in the self loop, any stray write shows up here
            repeat (10) @(posedge clock);
            #1 reset = 1'b1;
        end
        $display("register errors %0d, memory errors %0d, other errors %0d",
                 regErrors, memErrors, otherErrors);
        if (regErrors + memErrors + otherErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/procPkg.sv
verilog/procAlu.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/memWriteback.sv
verilog/processor.sv
sim/tbMemories.sv
sim/processorTb.sv

// File: Bender.yml
package:
  name: pipelined_processor

sources:
  # core, in compile order
  - verilog/procPkg.sv
  - verilog/procAlu.sv
  - verilog/fetchUnit.sv
  - verilog/decodeUnit.sv
  - verilog/executeUnit.sv
  - verilog/memWriteback.sv
  - verilog/processor.sv
  - target: simulation
    files:
      - sim/tbMemories.sv
      - sim/processorTb.sv
